//--- eth_loopback.f
+incdir+include
verilog/gmii_pkg.sv
verilog/frame_pkg.sv
verilog/gmii_rx_framer.sv
verilog/frame_fifo.sv
verilog/gmii_tx_framer.sv
verilog/eth_loopback.sv
tb/tb_eth_loopback.sv

//--- tb/tb_eth_loopback.sv
// Ethernet loopback testbench: frame stimulus, transmit monitor, reference queues, assertions
`timescale 1ns/1ns
`default_nettype none
`include "eth_loop_defs.svh"

module tb_eth_loopback
    import gmii_pkg::*;
    import frame_pkg::*;
();

    localparam int          MAX_LEN = 250;
    localparam int unsigned SEED    = 32'h085bd8f7;

    logic         clk;
    logic         rst;
    gmii_rx_t     gmii_rx;
    gmii_tx_t     gmii_tx;
    logic         frame_drop;
    drop_reason_t drop_reason;

    // Reference model state
    int           exp_len [$];
    logic [7:0]   exp_bytes [$];
    drop_reason_t drop_q [$];
    logic [7:0]   got [$];
    bit           first_sent;
    int           value_errs;
    int           other_errs;

    eth_loopback #(
        .FIFO_ADDR_W   (8),
        .MAX_FRAME_LEN (MAX_LEN)
    ) u_eth_loopback (
        .clk         (clk),
        .rst         (rst),
        .gmii_rx     (gmii_rx),
        .gmii_tx     (gmii_tx),
        .frame_drop  (frame_drop),
        .drop_reason (drop_reason)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input int exp_val, input int act_val);
        value_errs++;
        $display("** Error at %0t ns: %s expected 'h%0h, got 'h%0h",
                 $time, name, exp_val, act_val);
    endtask

    task automatic report_failure(input string msg);
        other_errs++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // Drop reason a frame should get, or -1 when it should come back
    function automatic int drop_for(input int len, input int er_pos, input bit no_room);
        if (no_room) return DROP_FULL;
        if (len > MAX_LEN) return DROP_OVERSIZE;
        if (er_pos >= 0 && er_pos < len) return DROP_ERROR;
        if (len < `ETH_MIN_FRAME_LEN) return DROP_RUNT;
        return -1;
    endfunction

    // One received frame, er_pos of -1 means a clean frame
    task automatic send_frame(input int pre_cnt, input int len, input int er_pos,
                              input int gap, input bit no_room);
        logic [7:0] payload [$];
        int         reason;
        int         i;
        for (i = 0; i < len; i++) begin
            payload.push_back(8'($urandom));
        end
        reason = drop_for(len, er_pos, no_room);
        if (reason < 0) begin
            exp_len.push_back(len);
            foreach (payload[j]) exp_bytes.push_back(payload[j]);
        end else begin
            drop_q.push_back(drop_reason_t'(reason));
        end
        first_sent = 1'b1;
        for (i = 0; i < pre_cnt; i++) begin
            @(negedge clk);
            gmii_rx <= '{data: `ETH_PREAMBLE_BYTE, dv: 1'b1, er: 1'b0};
        end
        @(negedge clk);
        gmii_rx <= '{data: `ETH_SFD_BYTE, dv: 1'b1, er: 1'b0};
        for (i = 0; i < len; i++) begin
            @(negedge clk);
            gmii_rx <= '{data: payload[i], dv: 1'b1, er: (i == er_pos)};
        end
        for (i = 0; i < gap; i++) begin
            @(negedge clk);
            gmii_rx <= '0;
        end
    endtask

    // Until every expected frame and drop has been seen
    task automatic wait_idle(input int max_cycles);
        int n;
        bit busy;
        n    = 0;
        busy = 1'b1;
        while (busy && n < max_cycles) begin
            @(negedge clk);
            busy = exp_len.size() != 0 || drop_q.size() != 0 || gmii_tx.en;
            n++;
        end
        if (busy) begin
            report_failure("timed out waiting for expected frames and drops");
        end
    endtask

    task automatic check_frame();
        int         n;
        int         i;
        logic [7:0] exp_byte;
        if (exp_len.size() == 0) return;
        n = exp_len.pop_front();
        assert (got.size() == n + 8)
            else report_mismatch("gmii_tx frame length", n + 8, got.size());
        for (i = 0; i < got.size() && i < n + 8; i++) begin
            if (i < `ETH_PREAMBLE_LEN) exp_byte = `ETH_PREAMBLE_BYTE;
            else if (i == `ETH_PREAMBLE_LEN) exp_byte = `ETH_SFD_BYTE;
            else exp_byte = exp_bytes[i - 8];
            assert (got[i] == exp_byte)
                else report_mismatch($sformatf("gmii_tx.data[%0d]", i), exp_byte, got[i]);
        end
        repeat (n) void'(exp_bytes.pop_front());
    endtask

    // Transmit monitor
    always @(posedge clk) begin
        if (rst) begin
            got.delete();
        end else if (gmii_tx.en) begin
            if (got.size() == 0) begin
                assert (exp_len.size() > 0)
                    else report_failure("gmii_tx sent a frame that should have been dropped");
            end
            got.push_back(gmii_tx.data);
        end else if (got.size() > 0) begin
            check_frame();
            got.delete();
        end
    end

    // Drop report against the expected reasons, in order
    always @(posedge clk) begin
        if (!rst && frame_drop) begin
            assert (drop_q.size() > 0)
                else report_failure("frame_drop pulsed for a frame that should pass");
            if (drop_q.size() > 0) begin
                assert (drop_reason == drop_q[0])
                    else report_mismatch("drop_reason", drop_q[0], drop_reason);
                void'(drop_q.pop_front());
            end
        end
    end

    assert property (@(posedge clk) $fell(rst) |-> !gmii_tx.en && !frame_drop)
        else report_failure("gmii_tx.en or frame_drop high right after reset");

    assert property (@(posedge clk) disable iff (rst) !first_sent |-> !gmii_tx.en)
        else report_failure("gmii_tx.en rose before any frame was received");

    assert property (@(posedge clk) disable iff (rst)
        $fell(gmii_tx.en) |-> !gmii_tx.en [*`ETH_IFG_LEN])
        else report_failure("inter-frame gap on gmii_tx shorter than required");

    assert property (@(posedge clk) disable iff (rst) frame_drop |=> !frame_drop)
        else report_failure("frame_drop held for more than one cycle");

    initial begin
        void'($urandom(SEED));
        value_errs = 0;
        other_errs = 0;
        first_sent = 1'b0;
        gmii_rx    = '0;
        rst        = 1'b1;
        repeat (4) @(negedge clk);
        rst <= 1'b0;
        repeat (10) @(negedge clk);

        // Short frame catches up, so the transmitter sends a burst
        send_frame(1, 100, -1, 1, 1'b0);
        send_frame(7, 64, -1, 20, 1'b0);
        wait_idle(1000);
        send_frame(0, MAX_LEN, -1, 20, 1'b0);
        wait_idle(1000);

        // Errored, runt and oversize frames
        send_frame(7, 100, 40, 12, 1'b0);
        send_frame(7, 63, -1, 12, 1'b0);
        send_frame(7, MAX_LEN + 1, -1, 12, 1'b0);
        wait_idle(1000);

        // Second full-size frame runs into the first one still held
        send_frame(7, MAX_LEN, -1, 1, 1'b0);
        send_frame(0, MAX_LEN, -1, 12, 1'b1);
        wait_idle(1000);
        send_frame(7, 100, -1, 12, 1'b0);
        wait_idle(1000);
        repeat (20) @(negedge clk);

        assert (exp_len.size() == 0 && drop_q.size() == 0)
            else report_failure("expected frames or drops never showed up");
        $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/eth_loopback.sv
// Ethernet loopback top: receive framer into frame FIFO into transmit framer
`timescale 1ns/1ns
`default_nettype none
`include "eth_loop_defs.svh"

module eth_loopback
    import gmii_pkg::*;
    import frame_pkg::*;
#(
    parameter int FIFO_ADDR_W   = `ETH_FIFO_ADDR_W,
    parameter int MAX_FRAME_LEN = `ETH_MAX_FRAME_LEN
) (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire gmii_rx_t     gmii_rx,
    output wire gmii_tx_t     gmii_tx,
    output wire logic         frame_drop,
    output wire drop_reason_t drop_reason
);

    wire frame_beat_t beat;
    wire logic        frame_ready;
    wire head_beat_t  head;
    wire logic        pop;

    gmii_rx_framer #(
        .MAX_FRAME_LEN(MAX_FRAME_LEN)
    ) u_rx_framer (
        .clk     (clk),
        .rst     (rst),
        .gmii_rx (gmii_rx),
        .beat    (beat)
    );

    // Store and forward, so only whole good frames go back out
    frame_fifo #(
        .ADDR_W(FIFO_ADDR_W)
    ) u_frame_fifo (
        .clk         (clk),
        .rst         (rst),
        .beat        (beat),
        .frame_ready (frame_ready),
        .head        (head),
        .pop         (pop),
        .frame_drop  (frame_drop),
        .drop_reason (drop_reason)
    );

    gmii_tx_framer u_tx_framer (
        .clk         (clk),
        .rst         (rst),
        .frame_ready (frame_ready),
        .head        (head),
        .pop         (pop),
        .gmii_tx     (gmii_tx)
    );

endmodule

`default_nettype wire

//--- verilog/gmii_tx_framer.sv
// GMII transmit framer: preamble, SFD, payload from the frame FIFO, inter-frame gap
`timescale 1ns/1ns
`default_nettype none
`include "eth_loop_defs.svh"

module gmii_tx_framer
    import gmii_pkg::*;
    import frame_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       frame_ready,
    input  wire head_beat_t head,
    output wire logic       pop,
    output gmii_tx_t        gmii_tx
);

    // One counter serves the preamble and the gap
    localparam int CNT_MAX = (`ETH_IFG_LEN > `ETH_PREAMBLE_LEN) ?
                             `ETH_IFG_LEN : `ETH_PREAMBLE_LEN;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);
    localparam logic [CNT_W-1:0] PRE_CNT = CNT_W'(`ETH_PREAMBLE_LEN);
    localparam logic [CNT_W-1:0] IFG_CNT = CNT_W'(`ETH_IFG_LEN);

    tx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic             out_last;

    // Take a byte right after the SFD and after every non-last byte
    assign pop = (state == TX_SFD) || (state == TX_DATA && !out_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            out_last <= 1'b0;
            gmii_tx  <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (frame_ready) begin
                        gmii_tx <= '{data: `ETH_PREAMBLE_BYTE, en: 1'b1};
                        cnt     <= CNT_W'(1);
                        state   <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    if (cnt == PRE_CNT) begin
                        gmii_tx.data <= `ETH_SFD_BYTE;
                        state        <= TX_SFD;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                TX_SFD, TX_DATA: begin
                    if (pop) begin
                        gmii_tx.data <= head.data;
                        out_last     <= head.last;
                        state        <= TX_DATA;
                    end else begin
                        // Last byte has been on the line for its cycle
                        gmii_tx.en <= 1'b0;
                        cnt        <= CNT_W'(1);
                        state      <= TX_GAP;
                    end
                end
                TX_GAP: begin
                    if (cnt == IFG_CNT) begin
                        state <= TX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // Full gap of idle line after the final payload byte
    assert property (@(posedge clk) disable iff (rst)
        (state == TX_DATA && !pop) |=> (state == TX_GAP && !gmii_tx.en) [*`ETH_IFG_LEN])
        else $error("gmii_tx_framer: inter-frame gap cut short");

endmodule

`default_nettype wire

//--- verilog/frame_fifo.sv
// Single-clock frame FIFO: commits good frames, rewinds bad or unfitting ones, drop report
`timescale 1ns/1ns
`default_nettype none
`include "eth_loop_defs.svh"

module frame_fifo
    import frame_pkg::*;
#(
    parameter int ADDR_W = `ETH_FIFO_ADDR_W
) (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire frame_beat_t   beat,
    output wire logic          frame_ready,
    output head_beat_t         head,
    input  wire logic          pop,
    output logic               frame_drop,
    output drop_reason_t       drop_reason
);

    localparam int DEPTH = 2 ** ADDR_W;

    head_beat_t mem [DEPTH];

    // Pointers carry one extra bit to tell full from empty
    logic [ADDR_W:0] wr_ptr;
    logic [ADDR_W:0] commit_ptr;
    logic [ADDR_W:0] rd_ptr;
    logic [ADDR_W:0] rd_ptr_nxt;
    logic [ADDR_W:0] occupancy;
    logic [ADDR_W:0] frame_cnt;
    logic            full;
    logic            skip;
    logic            commit_pend;
    logic            wr_en;
    logic            pop_last;

    function automatic drop_reason_t to_reason(input frame_end_t code);
        case (code)
            END_RUNT:     return DROP_RUNT;
            END_OVERSIZE: return DROP_OVERSIZE;
            default:      return DROP_ERROR;
        endcase
    endfunction

    assign occupancy   = wr_ptr - rd_ptr;
    // Occupancy tops out at DEPTH, so the extra bit alone means full
    assign full        = occupancy[ADDR_W];
    assign wr_en       = beat.valid && !skip && !full;
    assign pop_last    = pop && head.last;
    assign rd_ptr_nxt  = pop ? rd_ptr + 1'b1 : rd_ptr;
    assign frame_ready = frame_cnt != '0;

    // Byte store with show-ahead read, head re-read every cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= '{data: beat.data, last: beat.last};
        end
        head <= mem[rd_ptr_nxt[ADDR_W-1:0]];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            commit_ptr  <= '0;
            rd_ptr      <= '0;
            frame_cnt   <= '0;
            skip        <= 1'b0;
            commit_pend <= 1'b0;
            frame_drop  <= 1'b0;
            drop_reason <= DROP_ERROR;
        end else begin
            frame_drop  <= 1'b0;
            commit_pend <= 1'b0;

            if (beat.valid && skip) begin
                // Tail of a frame that already overflowed
                skip <= !beat.last;
            end else if (beat.valid && full) begin
                wr_ptr      <= commit_ptr;
                skip        <= !beat.last;
                frame_drop  <= 1'b1;
                drop_reason <= DROP_FULL;
            end else if (beat.valid && beat.last && beat.end_code != END_GOOD) begin
                wr_ptr      <= commit_ptr;
                frame_drop  <= 1'b1;
                drop_reason <= to_reason(beat.end_code);
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
                if (beat.last) begin
                    commit_ptr  <= wr_ptr + 1'b1;
                    commit_pend <= 1'b1;
                end
            end

            rd_ptr <= rd_ptr_nxt;

            // Frame is visible one cycle after the commit
            if (commit_pend && !pop_last) begin
                frame_cnt <= frame_cnt + 1'b1;
            end else if (!commit_pend && pop_last) begin
                frame_cnt <= frame_cnt - 1'b1;
            end
        end
    end

    // Consumer must not read past committed data
    assert property (@(posedge clk) disable iff (rst) pop |-> frame_ready)
        else $error("frame_fifo: pop with no committed frame");

    // Rewind and full logic keep the store within bounds
    assert property (@(posedge clk) disable iff (rst) occupancy <= DEPTH)
        else $error("frame_fifo: occupancy %0d above %0d", occupancy, DEPTH);

endmodule

`default_nettype wire

//--- verilog/gmii_rx_framer.sv
// GMII receive framer: preamble and SFD strip, length and error checks, frame beats
`timescale 1ns/1ns
`default_nettype none
`include "eth_loop_defs.svh"

module gmii_rx_framer
    import gmii_pkg::*;
    import frame_pkg::*;
#(
    parameter int MAX_FRAME_LEN = `ETH_MAX_FRAME_LEN
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire gmii_rx_t gmii_rx,
    output frame_beat_t   beat
);

    localparam int CNT_W = $clog2(MAX_FRAME_LEN + 1);
    localparam logic [CNT_W-1:0] MIN_CNT = CNT_W'(`ETH_MIN_FRAME_LEN);
    localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(MAX_FRAME_LEN);

    rx_state_t        state;
    logic [CNT_W-1:0] cnt;
    logic             err;
    logic [7:0]       hold;
    frame_end_t       end_sel;

    // Error wins over runt, oversize is decided on the fly
    always_comb begin
        if (err) begin
            end_sel = END_ERROR;
        end else if (cnt < MIN_CNT) begin
            end_sel = END_RUNT;
        end else begin
            end_sel = END_GOOD;
        end
    end

    // Each byte waits here one cycle until we know if it was the last
    always_ff @(posedge clk) begin
        if (state == RX_DATA && gmii_rx.dv) begin
            hold <= gmii_rx.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RX_IDLE;
            cnt   <= '0;
            err   <= 1'b0;
            beat  <= '0;
        end else begin
            beat.valid <= 1'b0;
            beat.last  <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    err <= gmii_rx.dv & gmii_rx.er;
                    if (gmii_rx.dv) begin
                        // No preamble at all is allowed
                        if (gmii_rx.data == `ETH_SFD_BYTE) begin
                            state <= RX_DATA;
                        end else begin
                            state <= RX_PREAMBLE;
                        end
                    end
                end
                RX_PREAMBLE: begin
                    if (!gmii_rx.dv) begin
                        state <= RX_IDLE;
                    end else begin
                        err <= err | gmii_rx.er;
                        if (gmii_rx.data == `ETH_SFD_BYTE) begin
                            state <= RX_DATA;
                        end
                    end
                end
                RX_DATA: begin
                    if (!gmii_rx.dv) begin
                        // End of frame, flush the held byte
                        beat.valid    <= cnt != '0;
                        beat.last     <= cnt != '0;
                        beat.data     <= hold;
                        beat.end_code <= end_sel;
                        state         <= RX_IDLE;
                    end else if (cnt == MAX_CNT) begin
                        // One byte too many, cut the frame here
                        beat.valid    <= 1'b1;
                        beat.last     <= 1'b1;
                        beat.data     <= hold;
                        beat.end_code <= END_OVERSIZE;
                        state         <= RX_DISCARD;
                    end else begin
                        err           <= err | gmii_rx.er;
                        beat.valid    <= cnt != '0;
                        beat.data     <= hold;
                        beat.end_code <= END_GOOD;
                        cnt           <= cnt + 1'b1;
                    end
                end
                RX_DISCARD: begin
                    if (!gmii_rx.dv) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // The end code only rides on a real beat
    assert property (@(posedge clk) disable iff (rst) beat.last |-> beat.valid)
        else $error("gmii_rx_framer: last set on a beat without valid");

endmodule

`default_nettype wire

//--- verilog/frame_pkg.sv
// Internal frame stream types, end codes, drop reasons and controller states
`default_nettype none

package frame_pkg;

    // How a received frame finished
    typedef enum logic [1:0] {
        END_GOOD     = 2'd0,
        END_ERROR    = 2'd1,
        END_RUNT     = 2'd2,
        END_OVERSIZE = 2'd3
    } frame_end_t;

    // One payload byte from the receive framer
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
        frame_end_t end_code;    // only looked at on the last beat
    } frame_beat_t;

    // Show-ahead byte at the buffer head
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } head_beat_t;

    typedef enum logic [1:0] {
        DROP_ERROR    = 2'd0,
        DROP_RUNT     = 2'd1,
        DROP_OVERSIZE = 2'd2,
        DROP_FULL     = 2'd3
    } drop_reason_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA,
        RX_DISCARD
    } rx_state_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_DATA,
        TX_GAP
    } tx_state_t;

endpackage

`default_nettype wire

//--- verilog/gmii_pkg.sv
// Line-side types of the byte-wide Ethernet port
`default_nettype none

package gmii_pkg;

    // Receive side, sampled every clock
    typedef struct packed {
        logic [7:0] data;
        logic       dv;
        logic       er;
    } gmii_rx_t;

    // Transmit side
    typedef struct packed {
        logic [7:0] data;
        logic       en;
    } gmii_tx_t;

endpackage

`default_nettype wire

//--- include/eth_loop_defs.svh
// Ethernet loopback constants: framing bytes, length limits, inter-frame gap, buffer size
`ifndef ETH_LOOP_DEFS_SVH
`define ETH_LOOP_DEFS_SVH

// Line framing bytes
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE      8'hD5

// Preamble bytes put on the line before the SFD
`define ETH_PREAMBLE_LEN  7

// Payload length limits in bytes, FCS included
`define ETH_MIN_FRAME_LEN 64
`define ETH_MAX_FRAME_LEN 1518

// Idle cycles between transmitted frames
`define ETH_IFG_LEN       12

// Frame store of 2048 bytes
`define ETH_FIFO_ADDR_W   11

`endif
